// File: rtl/iew_pkg.sv
`default_nettype none

package iew_pkg;

    localparam int XLEN              = 32;
    localparam int NR_AREGS          = 32;
    localparam int NR_PREGS          = 64;
    localparam int ROB_DEPTH_DEFAULT = 8;

    typedef logic [XLEN-1:0]                      xlen_t;
    typedef logic [$clog2(NR_AREGS)-1:0]          areg_id_t;
    typedef logic [$clog2(NR_PREGS)-1:0]          preg_id_t;
    // Also used as the instruction sequence number
    typedef logic [$clog2(ROB_DEPTH_DEFAULT)-1:0] rob_id_t;

    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLL   = 4'd5,
        OP_SRL   = 4'd6,
        OP_SRA   = 4'd7,
        OP_SLT   = 4'd8,
        OP_SLTU  = 4'd9,
        OP_LUI   = 4'd10,
        OP_AUIPC = 4'd11
    } fu_op_t;

    // Handed over by rename
    typedef struct packed {
        xlen_t    pc;
        areg_id_t rs1;
        logic     rs1_valid;
        areg_id_t rs2;
        logic     rs2_valid;
        preg_id_t prs1;
        logic     prs1_renamed;
        preg_id_t prs2;
        logic     prs2_renamed;
        logic     use_uimm;
        xlen_t    imm;
        fu_op_t   op;
        areg_id_t rd;
        logic     rd_valid;
        preg_id_t prd;
    } dispatch_t;

    typedef struct packed {
        xlen_t    pc;
        rob_id_t  id;
        preg_id_t prd;
        xlen_t    rs1val;
        xlen_t    rs2val;
        xlen_t    imm;
        fu_op_t   op;
    } fu_input_t;

    typedef struct packed {
        preg_id_t prd;
        xlen_t    rdval;
    } fu_output_t;

    typedef struct packed {
        logic     valid;
        logic     completed;
        xlen_t    pc;
        preg_id_t prd;
        areg_id_t ard;
        logic     needprf2arf;
    } rob_entry_t;

endpackage

`default_nettype wire

// File: rtl/regfile.sv
`default_nettype none

// Register array with combinational reads and one write port
module regfile #(
    parameter int  NREGS  = 32,
    parameter int  NREAD  = 2,
    parameter type DATA_T = logic,
    localparam int AW     = $clog2(NREGS)
) (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic                       we_i,
    input  wire logic [AW-1:0]              waddr_i,
    input  wire DATA_T                      wdata_i,
    input  wire logic [NREAD-1:0][AW-1:0]   raddr_i,
    output DATA_T     [NREAD-1:0]           rdata_o
);

    DATA_T mem [NREGS];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NREGS; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Reads return the value before this cycle's write
    always_comb begin
        for (int i = 0; i < NREAD; i++) begin
            rdata_o[i] = mem[raddr_i[i]];
        end
    end

endmodule

`default_nettype wire

// File: rtl/operand_read.sv
`default_nettype none

module operand_read
    import iew_pkg::*;
(
    input  wire dispatch_t       dispatch_i,
    // PRF and scoreboard share the read addresses
    output preg_id_t [1:0]       prf_raddr_o,
    input  wire xlen_t [1:0]     prf_rdata_i,
    input  wire logic [1:0]      sb_rdata_i,
    output areg_id_t [1:0]       arf_raddr_o,
    input  wire xlen_t [1:0]     arf_rdata_i,
    input  wire fu_output_t      bypass_i,
    input  wire logic            bypass_valid_i,
    output xlen_t                rs1val_o,
    output xlen_t                rs2val_o,
    output logic                 operands_ready_o
);

    logic  [1:0] renamed;
    logic  [1:0] bp_hit;
    xlen_t [1:0] src_val;
    logic  [1:0] src_rdy;
    logic        rs1_rdy;
    logic        rs2_rdy;

    assign prf_raddr_o[0] = dispatch_i.prs1;
    assign prf_raddr_o[1] = dispatch_i.prs2;
    assign arf_raddr_o[0] = dispatch_i.rs1;
    assign arf_raddr_o[1] = dispatch_i.rs2;

    assign renamed[0] = dispatch_i.prs1_renamed;
    assign renamed[1] = dispatch_i.prs2_renamed;

    // Source value lookup with same-cycle bypass
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            bp_hit[i] = bypass_valid_i && (bypass_i.prd == prf_raddr_o[i]);
            if (!renamed[i]) begin
                // Committed value is always available
                src_val[i] = arf_rdata_i[i];
                src_rdy[i] = 1'b1;
            end else if (bp_hit[i]) begin
                src_val[i] = bypass_i.rdval;
                src_rdy[i] = 1'b1;
            end else begin
                src_val[i] = prf_rdata_i[i];
                src_rdy[i] = sb_rdata_i[i];
            end
        end
    end

    // rs1 selection
    always_comb begin
        if (dispatch_i.op == OP_AUIPC) begin
            rs1val_o = dispatch_i.pc;
            rs1_rdy  = 1'b1;
        end else if (dispatch_i.use_uimm) begin
            // CSR immediate forms carry the uimm in the rs1 field
            rs1val_o = XLEN'(dispatch_i.rs1);
            rs1_rdy  = 1'b1;
        end else if (!dispatch_i.rs1_valid) begin
            rs1val_o = '0;
            rs1_rdy  = 1'b1;
        end else begin
            rs1val_o = src_val[0];
            rs1_rdy  = src_rdy[0];
        end
    end

    // rs2 takes the immediate when there is no second source
    always_comb begin
        if (!dispatch_i.rs2_valid) begin
            rs2val_o = dispatch_i.imm;
            rs2_rdy  = 1'b1;
        end else begin
            rs2val_o = src_val[1];
            rs2_rdy  = src_rdy[1];
        end
    end

    assign operands_ready_o = rs1_rdy && rs2_rdy;

endmodule

`default_nettype wire

// File: rtl/rob.sv
`default_nettype none

module rob
    import iew_pkg::*;
#(
    parameter int DEPTH = ROB_DEPTH_DEFAULT
) (
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire logic       push_i,
    input  wire rob_entry_t push_entry_i,
    output rob_id_t         tail_id_o,
    output logic            not_full_o,
    input  wire logic       cmpl_valid_i,
    input  wire rob_id_t    cmpl_id_i,
    input  wire logic       pop_i,
    output rob_entry_t      head_o
);

    rob_entry_t       entries [DEPTH];
    logic [DEPTH-1:0] allocated;
    logic [DEPTH-1:0] done;
    rob_id_t          issue_ptr;
    rob_id_t          retire_ptr;
    rob_id_t          issue_ptr_nxt;
    rob_id_t          retire_ptr_nxt;

    // Pointers wrap at DEPTH
    assign issue_ptr_nxt  = (issue_ptr == rob_id_t'(DEPTH - 1)) ? '0 : issue_ptr + rob_id_t'(1);
    assign retire_ptr_nxt = (retire_ptr == rob_id_t'(DEPTH - 1)) ? '0 : retire_ptr + rob_id_t'(1);

    assign tail_id_o  = issue_ptr;
    assign not_full_o = !allocated[issue_ptr];

    // Control state
    always_ff @(posedge clk) begin
        if (!rstn) begin
            issue_ptr  <= '0;
            retire_ptr <= '0;
            allocated  <= '0;
            done       <= '0;
        end else begin
            if (cmpl_valid_i) begin
                done[cmpl_id_i] <= 1'b1;
            end
            if (push_i) begin
                allocated[issue_ptr] <= 1'b1;
                done[issue_ptr]      <= 1'b0;
                issue_ptr            <= issue_ptr_nxt;
            end
            if (pop_i) begin
                allocated[retire_ptr] <= 1'b0;
                retire_ptr            <= retire_ptr_nxt;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (push_i) begin
            entries[issue_ptr] <= push_entry_i;
        end
    end

    always_comb begin
        head_o           = entries[retire_ptr];
        head_o.valid     = allocated[retire_ptr];
        head_o.completed = done[retire_ptr];
    end

endmodule

`default_nettype wire

// File: rtl/retire_commit.sv
`default_nettype none

module retire_commit
    import iew_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rstn,
    input  wire rob_entry_t head_i,
    output logic            pop_o,
    output preg_id_t        prf_raddr_o,
    input  wire xlen_t      prf_rdata_i,
    output rob_entry_t      retire_o,
    output xlen_t           retire_val_o,
    output logic            arf_we_o,
    output areg_id_t        arf_waddr_o,
    output xlen_t           arf_wdata_o
);

    logic       ret_valid_q;
    rob_entry_t ret_entry_q;
    xlen_t      ret_val_q;

    assign pop_o       = head_i.valid && head_i.completed;
    assign prf_raddr_o = head_i.prd;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ret_valid_q <= 1'b0;
        end else begin
            ret_valid_q <= pop_o;
        end
    end

    // Head entry and its result are held one cycle behind the pop
    always_ff @(posedge clk) begin
        ret_entry_q <= head_i;
        ret_val_q   <= prf_rdata_i;
    end

    always_comb begin
        retire_o       = ret_entry_q;
        retire_o.valid = ret_valid_q;
    end
    assign retire_val_o = ret_val_q;

    // Architectural update at commit
    assign arf_we_o    = ret_valid_q && ret_entry_q.needprf2arf;
    assign arf_waddr_o = ret_entry_q.ard;
    assign arf_wdata_o = ret_val_q;

endmodule

`default_nettype wire

// File: rtl/iew.sv
`default_nettype none

module iew
    import iew_pkg::*;
#(
    parameter int ROB_DEPTH = ROB_DEPTH_DEFAULT
) (
    input  wire logic       clk,
    input  wire logic       rstn,
    // From rename
    input  wire dispatch_t  dispatch_i,
    input  wire logic       dispatch_valid_i,
    output logic            dispatch_ready_o,
    // To execute
    output fu_input_t       issue_o,
    output logic            issue_valid_o,
    input  wire logic       fu_ready_i,
    // From execute
    input  wire fu_output_t bypass_i,
    input  wire logic       bypass_valid_i,
    input  wire fu_output_t wb_i,
    input  wire logic       wb_valid_i,
    input  wire logic       cmpl_valid_i,
    input  wire rob_id_t    cmpl_id_i,
    // Retire observation
    output rob_entry_t      retire_o,
    output xlen_t           retire_val_o
);

    // Ports 0 and 1 for operands, port 2 for the retire read
    preg_id_t [2:0] prf_raddr;
    xlen_t    [2:0] prf_rdata;
    areg_id_t [1:0] arf_raddr;
    xlen_t    [1:0] arf_rdata;
    logic     [1:0] sb_rdata;
    logic           sb_we;
    preg_id_t       sb_waddr;
    logic           sb_wdata;
    logic           arf_we;
    areg_id_t       arf_waddr;
    xlen_t          arf_wdata;
    xlen_t          rs1val;
    xlen_t          rs2val;
    logic           operands_ready;
    logic           issue_fire;
    rob_id_t        rob_tail;
    logic           rob_not_full;
    rob_entry_t     rob_push_entry;
    rob_entry_t     rob_head;
    logic           rob_pop;

    regfile #(.NREGS(NR_PREGS), .NREAD(3), .DATA_T(xlen_t)) prf (
        .clk     (clk),
        .rstn    (rstn),
        .we_i    (wb_valid_i),
        .waddr_i (wb_i.prd),
        .wdata_i (wb_i.rdval),
        .raddr_i (prf_raddr),
        .rdata_o (prf_rdata)
    );

    regfile #(.NREGS(NR_AREGS), .NREAD(2), .DATA_T(xlen_t)) arf (
        .clk     (clk),
        .rstn    (rstn),
        .we_i    (arf_we),
        .waddr_i (arf_waddr),
        .wdata_i (arf_wdata),
        .raddr_i (arf_raddr),
        .rdata_o (arf_rdata)
    );

    // Scoreboard holds one ready bit per physical register
    regfile #(.NREGS(NR_PREGS), .NREAD(2), .DATA_T(logic)) scoreboard (
        .clk     (clk),
        .rstn    (rstn),
        .we_i    (sb_we),
        .waddr_i (sb_waddr),
        .wdata_i (sb_wdata),
        .raddr_i (prf_raddr[1:0]),
        .rdata_o (sb_rdata)
    );

    operand_read u_operand_read (
        .dispatch_i       (dispatch_i),
        .prf_raddr_o      (prf_raddr[1:0]),
        .prf_rdata_i      (prf_rdata[1:0]),
        .sb_rdata_i       (sb_rdata),
        .arf_raddr_o      (arf_raddr),
        .arf_rdata_i      (arf_rdata),
        .bypass_i         (bypass_i),
        .bypass_valid_i   (bypass_valid_i),
        .rs1val_o         (rs1val),
        .rs2val_o         (rs2val),
        .operands_ready_o (operands_ready)
    );

    // Issue handshake
    assign issue_fire       = dispatch_valid_i && operands_ready && fu_ready_i && rob_not_full;
    assign issue_valid_o    = issue_fire;
    assign dispatch_ready_o = !dispatch_valid_i || issue_fire;

    assign issue_o.pc     = dispatch_i.pc;
    assign issue_o.id     = rob_tail;
    assign issue_o.prd    = dispatch_i.prd;
    assign issue_o.rs1val = rs1val;
    assign issue_o.rs2val = rs2val;
    assign issue_o.imm    = dispatch_i.imm;
    assign issue_o.op     = dispatch_i.op;

    // Write-back sets, issue clears; write-back owns the port on a collision
    assign sb_we    = wb_valid_i || (issue_fire && dispatch_i.rd_valid);
    assign sb_waddr = wb_valid_i ? wb_i.prd : dispatch_i.prd;
    assign sb_wdata = wb_valid_i;

    assign rob_push_entry.valid       = 1'b1;
    assign rob_push_entry.completed   = 1'b0;
    assign rob_push_entry.pc          = dispatch_i.pc;
    assign rob_push_entry.prd         = dispatch_i.prd;
    assign rob_push_entry.ard         = dispatch_i.rd;
    assign rob_push_entry.needprf2arf = dispatch_i.rd_valid;

    rob #(.DEPTH(ROB_DEPTH)) u_rob (
        .clk          (clk),
        .rstn         (rstn),
        .push_i       (issue_fire),
        .push_entry_i (rob_push_entry),
        .tail_id_o    (rob_tail),
        .not_full_o   (rob_not_full),
        .cmpl_valid_i (cmpl_valid_i),
        .cmpl_id_i    (cmpl_id_i),
        .pop_i        (rob_pop),
        .head_o       (rob_head)
    );

    retire_commit u_retire_commit (
        .clk          (clk),
        .rstn         (rstn),
        .head_i       (rob_head),
        .pop_o        (rob_pop),
        .prf_raddr_o  (prf_raddr[2]),
        .prf_rdata_i  (prf_rdata[2]),
        .retire_o     (retire_o),
        .retire_val_o (retire_val_o),
        .arf_we_o     (arf_we),
        .arf_waddr_o  (arf_waddr),
        .arf_wdata_o  (arf_wdata)
    );

endmodule

`default_nettype wire

// File: include/iew_tb_cases.svh
`ifndef IEW_TB_CASES_SVH
`define IEW_TB_CASES_SVH

// First line of a row holds name, dv, op, pc, rs1, rs1_v, prs1, prs1_ren, rs2, rs2_v,
// prs2, prs2_ren, imm, rd, rd_v, prd and fu_ready
// Second line holds wb_v, wb_prd, wb_val, bp_v, bp_prd, bp_val, cmpl_v, cmpl_id and the
// expected dispatch_ready, issue_valid, issue id, rs1val, rs2val, retire valid, ard, prd, value
add_case("wb_before_clear", 0, OP_ADD, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1,
         1, 10, 'h55550005, 0, 0, 0, 0, 0, 1, 0, 0, 'h0, 'h0, 0, 0, 0, 'h0);
add_case("add_arf", 1, OP_ADD, 'h100, 1, 1, 0, 0, 2, 1, 0, 0, 0, 5, 1, 10, 1,
         0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 'h0, 'h0, 0, 0, 0, 'h0);
add_case("auipc", 1, OP_AUIPC, 'h200, 0, 0, 0, 0, 0, 0, 0, 0, 'h3000, 6, 1, 11, 1,
         0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 'h200, 'h3000, 0, 0, 0, 'h0);
add_case("wait_bypass", 1, OP_ADD, 'h300, 5, 1, 10, 1, 0, 0, 0, 0, 4, 7, 1, 12, 1,
         0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h0, 'h0, 0, 0, 0, 'h0);
add_case("bypass_hit", 1, OP_ADD, 'h300, 5, 1, 10, 1, 0, 0, 0, 0, 4, 7, 1, 12, 1,
         0, 0, 0, 1, 10, 'hAAAA0001, 0, 0, 1, 1, 2, 'hAAAA0001, 'h4, 0, 0, 0, 'h0);
add_case("wb_prf", 0, OP_ADD, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1,
         1, 10, 'hAAAA0001, 0, 0, 0, 0, 0, 1, 0, 0, 'h0, 'h0, 0, 0, 0, 'h0);
add_case("fu_stall", 1, OP_ADD, 'h400, 5, 1, 10, 1, 3, 1, 0, 0, 0, 8, 1, 13, 0,
         1, 11, 'hBBBB0002, 0, 0, 0, 0, 0, 0, 0, 0, 'h0, 'h0, 0, 0, 0, 'h0);
add_case("prf_read", 1, OP_ADD, 'h400, 5, 1, 10, 1, 3, 1, 0, 0, 0, 8, 1, 13, 1,
         0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 3, 'hAAAA0001, 'h0, 0, 0, 0, 'h0);
add_case("fill_4", 1, OP_ADD, 'h500, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 1,
         1, 12, 'hCCCC0003, 0, 0, 0, 1, 1, 1, 1, 4, 'h0, 'h1, 0, 0, 0, 'h0);
add_case("fill_5", 1, OP_ADD, 'h504, 0, 0, 0, 0, 0, 0, 0, 0, 2, 0, 0, 0, 1,
         1, 13, 'hDDDD0004, 0, 0, 0, 0, 0, 1, 1, 5, 'h0, 'h2, 0, 0, 0, 'h0);
add_case("fill_6", 1, OP_ADD, 'h508, 0, 0, 0, 0, 0, 0, 0, 0, 3, 0, 0, 0, 1,
         0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 6, 'h0, 'h3, 0, 0, 0, 'h0);
add_case("fill_7", 1, OP_ADD, 'h50c, 0, 0, 0, 0, 0, 0, 0, 0, 4, 0, 0, 0, 1,
         0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 7, 'h0, 'h4, 0, 0, 0, 'h0);
add_case("rob_full", 1, OP_ADD, 'h600, 1, 1, 0, 0, 0, 0, 0, 0, 8, 9, 1, 14, 1,
         0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 'h0, 'h0, 0, 0, 0, 'h0);
add_case("cmpl_head", 1, OP_ADD, 'h600, 1, 1, 0, 0, 0, 0, 0, 0, 8, 9, 1, 14, 1,
         0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 'h0, 'h0, 0, 0, 0, 'h0);
add_case("pop_head", 1, OP_ADD, 'h600, 1, 1, 0, 0, 0, 0, 0, 0, 8, 9, 1, 14, 1,
         0, 0, 0, 0, 0, 0, 1, 2, 0, 0, 0, 'h0, 'h0, 0, 0, 0, 'h0);
add_case("retire_0", 1, OP_ADD, 'h600, 1, 1, 0, 0, 0, 0, 0, 0, 8, 9, 1, 14, 1,
         0, 0, 0, 0, 0, 0, 1, 3, 1, 1, 0, 'h0, 'h8, 1, 5, 10, 'hAAAA0001);
add_case("arf_commit", 1, OP_ADD, 'h700, 5, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1,
         0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 'hAAAA0001, 'h0, 1, 6, 11, 'hBBBB0002);
add_case("retire_2", 0, OP_ADD, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1,
         0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 'h0, 'h0, 1, 7, 12, 'hCCCC0003);
add_case("retire_3", 0, OP_ADD, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1,
         0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 'h0, 'h0, 1, 8, 13, 'hDDDD0004);
add_case("drain", 0, OP_ADD, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1,
         0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 'h0, 'h0, 0, 0, 0, 'h0);

`endif

// File: bench/iew_tb.sv
`default_nettype none

module iew_tb
    import iew_pkg::*;
();

    // One row per clock cycle
    typedef struct {
        string      name;
        logic       dv;
        dispatch_t  d;
        logic       fu;
        logic       wbv;
        fu_output_t wb;
        logic       bpv;
        fu_output_t bp;
        logic       cv;
        rob_id_t    cid;
        logic       exp_dready;
        logic       exp_ivalid;
        rob_id_t    exp_id;
        xlen_t      exp_rs1;
        xlen_t      exp_rs2;
        logic       exp_rvalid;
        areg_id_t   exp_ard;
        preg_id_t   exp_prd;
        xlen_t      exp_rval;
    } case_t;

    logic       clk = 1'b0;
    logic       rstn;
    dispatch_t  dispatch;
    logic       dispatch_valid;
    logic       dispatch_ready;
    fu_input_t  issue;
    logic       issue_valid;
    logic       fu_ready;
    fu_output_t bypass;
    logic       bypass_valid;
    fu_output_t wb;
    logic       wb_valid;
    logic       cmpl_valid;
    rob_id_t    cmpl_id;
    rob_entry_t retire;
    xlen_t      retire_val;

    case_t cases[$];
    int    check_count    = 0;
    int    error_count    = 0;
    int    cycle_cnt      = 0;
    int    timeout_cycles = 0;

    iew #(.ROB_DEPTH(ROB_DEPTH_DEFAULT)) iew_inst (
        .clk              (clk),
        .rstn             (rstn),
        .dispatch_i       (dispatch),
        .dispatch_valid_i (dispatch_valid),
        .dispatch_ready_o (dispatch_ready),
        .issue_o          (issue),
        .issue_valid_o    (issue_valid),
        .fu_ready_i       (fu_ready),
        .bypass_i         (bypass),
        .bypass_valid_i   (bypass_valid),
        .wb_i             (wb),
        .wb_valid_i       (wb_valid),
        .cmpl_valid_i     (cmpl_valid),
        .cmpl_id_i        (cmpl_id),
        .retire_o         (retire),
        .retire_val_o     (retire_val)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout: run did not end within %0d cycles", timeout_cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic add_case(
        input string  name,
        input int     dv,
        input fu_op_t op,
        input int     pc, rs1, r1v, prs1, r1ren, rs2, r2v, prs2, r2ren, imm, rd, rdv, prd, fu,
        input int     wbv, wbprd, wbval, bpv, bpprd, bpval, cv, cid,
        input int     xdr, xiv, xid, xrs1, xrs2, xrv, xard, xprd, xrval
    );
        case_t c;
        c.name           = name;
        c.dv             = dv[0];
        c.d              = '0;
        c.d.pc           = pc;
        c.d.rs1          = areg_id_t'(rs1);
        c.d.rs1_valid    = r1v[0];
        c.d.prs1         = preg_id_t'(prs1);
        c.d.prs1_renamed = r1ren[0];
        c.d.rs2          = areg_id_t'(rs2);
        c.d.rs2_valid    = r2v[0];
        c.d.prs2         = preg_id_t'(prs2);
        c.d.prs2_renamed = r2ren[0];
        c.d.imm          = imm;
        c.d.op           = op;
        c.d.rd           = areg_id_t'(rd);
        c.d.rd_valid     = rdv[0];
        c.d.prd          = preg_id_t'(prd);
        c.fu             = fu[0];
        c.wbv            = wbv[0];
        c.wb.prd         = preg_id_t'(wbprd);
        c.wb.rdval       = wbval;
        c.bpv            = bpv[0];
        c.bp.prd         = preg_id_t'(bpprd);
        c.bp.rdval       = bpval;
        c.cv             = cv[0];
        c.cid            = rob_id_t'(cid);
        c.exp_dready     = xdr[0];
        c.exp_ivalid     = xiv[0];
        c.exp_id         = rob_id_t'(xid);
        c.exp_rs1        = xrs1;
        c.exp_rs2        = xrs2;
        c.exp_rvalid     = xrv[0];
        c.exp_ard        = areg_id_t'(xard);
        c.exp_prd        = preg_id_t'(xprd);
        c.exp_rval       = xrval;
        cases.push_back(c);
    endtask

    task automatic load_cases();
        `include "iew_tb_cases.svh"
    endtask

    task automatic drive_idle();
        dispatch       <= '0;
        dispatch_valid <= 1'b0;
        fu_ready       <= 1'b0;
        bypass         <= '0;
        bypass_valid   <= 1'b0;
        wb             <= '0;
        wb_valid       <= 1'b0;
        cmpl_valid     <= 1'b0;
        cmpl_id        <= '0;
    endtask

    task automatic apply_case(input case_t c);
        dispatch       <= c.d;
        dispatch_valid <= c.dv;
        fu_ready       <= c.fu;
        bypass         <= c.bp;
        bypass_valid   <= c.bpv;
        wb             <= c.wb;
        wb_valid       <= c.wbv;
        cmpl_valid     <= c.cv;
        cmpl_id        <= c.cid;
    endtask

    task automatic compare_value(input string name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s %s: expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    task automatic verify_outputs(input case_t c);
        compare_value(c.name, "dispatch_ready", 32'(c.exp_dready), 32'(dispatch_ready));
        compare_value(c.name, "issue_valid", 32'(c.exp_ivalid), 32'(issue_valid));
        // Payload only matters while issue is valid
        if (c.exp_ivalid) begin
            compare_value(c.name, "issue id", 32'(c.exp_id), 32'(issue.id));
            compare_value(c.name, "rs1val", c.exp_rs1, issue.rs1val);
            compare_value(c.name, "rs2val", c.exp_rs2, issue.rs2val);
            compare_value(c.name, "issue pc", c.d.pc, issue.pc);
            compare_value(c.name, "issue prd", 32'(c.d.prd), 32'(issue.prd));
            compare_value(c.name, "issue imm", c.d.imm, issue.imm);
            compare_value(c.name, "issue op", 32'(c.d.op), 32'(issue.op));
        end
        compare_value(c.name, "retire valid", 32'(c.exp_rvalid), 32'(retire.valid));
        if (c.exp_rvalid) begin
            compare_value(c.name, "retire ard", 32'(c.exp_ard), 32'(retire.ard));
            compare_value(c.name, "retire prd", 32'(c.exp_prd), 32'(retire.prd));
            compare_value(c.name, "retire value", c.exp_rval, retire_val);
        end
    endtask

    initial begin
        drive_idle();
        rstn <= 1'b0;
        load_cases();
        timeout_cycles = cases.size() * 4 + 20;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        // Drive on the rising edge, sample at the falling edge
        foreach (cases[i]) begin
            @(posedge clk);
            apply_case(cases[i]);
            @(negedge clk);
            verify_outputs(cases[i]);
        end
        @(posedge clk);
        drive_idle();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+include
rtl/iew_pkg.sv
rtl/regfile.sv
rtl/operand_read.sv
rtl/rob.sv
rtl/retire_commit.sv
rtl/iew.sv
bench/iew_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := iew_tb
FILELIST  := files.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
